// File: tb.f
hdl/gb_loader_pkg.sv
hdl/download_decoder.sv
hdl/boot_rom_tracker.sv
hdl/cheat_code_loader.sv
hdl/backup_ram_sequencer.sv
hdl/gb_loader_top.sv
tb/gb_loader_properties.sv
tb/tb_gb_loader.sv

// File: Makefile
# Verilator build and run for the host loader testbench

VERILATOR ?= verilator
TOP       ?= tb_gb_loader
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
		echo "$$out"; \
		echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_gb_loader.sv
/*
 * Random-stimulus testbench for the host loader. Sends cheat, boot ROM and
 * cart downloads, answers SD block requests with random latency, and checks
 * every result against a model kept here. Built from the file list.
 */

module tb_gb_loader;

	timeunit 1ns;
	timeprecision 1ps;

	// Worst case cycles per test
	localparam int BLOCK_MAX    = 8 + 256 + 4;
	localparam int MAX_BLOCKS   = 4 + 1;
	localparam int XFER_CYCLES  = MAX_BLOCKS * BLOCK_MAX + 8;
	localparam int CHEAT_CYCLES = 3 * (8 + 4);
	localparam int BOOT_CYCLES  = 3 * (400 + 4);
	localparam int DMG_CYCLES   = 2 * (8 + 4) + 8;
	localparam int CART_CYCLES  = 16 + 4 + XFER_CYCLES;
	localparam int AUTO_CYCLES  = 8 + XFER_CYCLES;
	localparam int CYCLE_LIMIT  = 2 + CHEAT_CYCLES + BOOT_CYCLES + DMG_CYCLES
		+ CART_CYCLES + XFER_CYCLES + AUTO_CYCLES + 200;

	logic                                   clk_sys;
	logic                                   reset;
	logic                                   ioctl_download;
	logic [7:0]                             filetype;
	logic                                   ioctl_wr;
	logic [gb_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [gb_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout;
	logic                                   is_gbc;
	logic                                   img_mounted;
	logic                                   img_readonly;
	logic                                   img_size_nz;
	logic                                   cart_has_save;
	logic [7:0]                             ram_mask_file;
	logic                                   rtc_inuse;
	logic [gb_loader_pkg::RTC_TS_W-1:0]     rtc_timestamp;
	logic [gb_loader_pkg::RTC_SAVED_W-1:0]  rtc_saved;
	logic                                   cram_wr;
	logic                                   osd_status;
	logic                                   autosave_en;
	logic                                   bk_load_req;
	logic                                   bk_save_req;
	logic                                   sd_ack;
	logic [7:0]                             sd_buff_addr;
	logic                                   sd_buff_wr;
	logic [gb_loader_pkg::IOCTL_DATA_W-1:0] bk_q;
	logic                                   fastboot_available;
	logic                                   boot_gba_available;
	logic                                   using_real_cgb_bios;
	logic [gb_loader_pkg::GG_CODE_W-1:0]    gg_code;
	logic [gb_loader_pkg::SD_LBA_W-1:0]     sd_lba;
	logic                                   sd_rd;
	logic                                   sd_wr;
	logic [gb_loader_pkg::IOCTL_DATA_W-1:0] sd_buff_din;
	logic [gb_loader_pkg::BK_ADDR_W-1:0]    bk_addr;
	logic                                   bk_wr;
	logic                                   bk_rtc_wr;
	logic                                   bk_loading;
	logic                                   sav_pending;
	logic                                   busy;

	logic [31:0] rng_state = 32'd20;
	logic [15:0] word_q[$];
	logic [31:0] lba_log[$];
	logic        read_log[$];
	logic [17:0] sum_m;
	logic        custom_cgb_m;
	logic        custom_dmg_m;
	logic        strobe_prev;
	int          cycle_count = 0;
	int          error_count = 0;
	int          test_count = 0;
	int          fail_count = 0;
	int          test_start_errors = 0;

	gb_loader_top dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Run stopped, no finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers and compare tasks

	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[30:15];
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic report_fault(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		error_count++;
	endtask

	task automatic check_code(input string name, input logic [128:0] got,
		input logic [128:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
			error_count++;
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
			error_count++;
		end
	endtask

	task automatic check_lba(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
			error_count++;
		end
	endtask

	task automatic check_addr(input string name, input logic [16:0] got,
		input logic [16:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
			error_count++;
		end
	endtask

	task automatic begin_test();
		test_start_errors = error_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count == test_start_errors) begin
			$display("test %s ok", name);
		end else begin
			$display("test %s failed with %0d errors", name,
				error_count - test_start_errors);
			fail_count++;
		end
	endtask

	// Protocol rules sampled away from the clock edge
	always @(negedge clk_sys) begin
		if (!reset) begin
			if (sd_rd && sd_wr)
				report_fault("sd_rd and sd_wr are high together");
			if ((sd_rd || sd_wr) && !busy)
				report_fault("SD request raised while the sequencer is idle");
			if (strobe_prev && gg_code[128])
				report_fault("cheat strobe lasted two cycles");
		end
		strobe_prev = (gg_code[128] === 1'b1);
	end

	////////////////////////////////////////////////////////////////////////////
	// Download driver and model

	// Writes word_q at byte offsets 0, 2, 4 and on, one word per cycle
	task automatic send_words();
		for (int i = 0; i < word_q.size(); i++) begin
			ioctl_addr = gb_loader_pkg::IOCTL_ADDR_W'(2 * i);
			ioctl_dout = word_q[i];
			ioctl_wr = 1'b1;
			next_cycle();
		end
		ioctl_wr = 1'b0;
	endtask

	task automatic load_file(input logic [7:0] ft);
		filetype = ft;
		ioctl_download = 1'b1;
		send_words();
		ioctl_download = 1'b0;
		next_cycle();
	endtask

	task automatic add_word(input logic [15:0] w);
		word_q.push_back(w);
		sum_m = sum_m + 18'(w[15:8]) + 18'(w[7:0]);
	endtask

	// Image whose byte sum lands on the target
	task automatic craft_image(input int target);
		int rem;
		int hi;
		word_q.delete();
		sum_m = '0;
		rem = target;
		while (rem > 0) begin
			if (rem >= 510) begin
				add_word(16'hFFFF);
				rem -= 510;
			end else begin
				hi = (rem > 255) ? 255 : rem;
				add_word({8'(hi), 8'(rem - hi)});
				rem = 0;
			end
		end
	endtask

	task automatic check_boot_outputs();
		logic real_exp;
		logic gba_exp;
		logic fast_exp;
		real_exp = (sum_m == 18'h2F3EA);
		gba_exp = !custom_cgb_m || real_exp || sum_m == 18'h2E351;
		fast_exp = !((is_gbc && custom_cgb_m && sum_m != 18'h2E351)
			|| (!is_gbc && custom_dmg_m));
		check_flag("using_real_cgb_bios", using_real_cgb_bios, real_exp);
		check_flag("boot_gba_available", boot_gba_available, gba_exp);
		check_flag("fastboot_available", fastboot_available, fast_exp);
	endtask

	// Cheat layout {strobe, flags, address, compare, replace}
	function automatic logic [128:0] place_cheat_word(input logic [128:0] code,
		input int offset, input logic [15:0] w);
		logic [128:0] c;
		c = code;
		case (offset)
			0:  c[111:96] = w;
			2:  c[127:112] = w;
			4:  c[79:64] = w;
			6:  c[95:80] = w;
			8:  c[47:32] = w;
			10: c[63:48] = w;
			12: c[15:0] = w;
			14: c[31:16] = w;
			default: ;
		endcase
		return c;
	endfunction

	function automatic logic [15:0] rtc_word(input logic [7:0] addr);
		case (addr)
			8'd0:    return rtc_timestamp[15:0];
			8'd1:    return rtc_timestamp[31:16];
			8'd2:    return rtc_saved[15:0];
			8'd3:    return rtc_saved[31:16];
			8'd4:    return rtc_saved[47:32];
			default: return 16'hFFFF;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// SD host responder

	task automatic serve_block();
		logic        is_read;
		logic [31:0] lba;
		logic        rtc;
		int          delay;
		int          a;
		is_read = sd_rd;
		lba = sd_lba;
		rtc = (lba > {24'd0, ram_mask_file});
		lba_log.push_back(lba);
		read_log.push_back(is_read);
		delay = 1 + int'(next_rand() % 16'd8);
		repeat (delay) next_cycle();
		sd_ack = 1'b1;
		for (a = 0; a < 256; a++) begin
			sd_buff_addr = 8'(a);
			sd_buff_wr = is_read;
			bk_q = next_rand();
			#1;
			// Request level drops one cycle after the ack rises
			if (a == 1) begin
				check_flag("sd_rd", sd_rd, 1'b0);
				check_flag("sd_wr", sd_wr, 1'b0);
			end
			check_addr("bk_addr", bk_addr, {1'b0, lba[7:0], 8'(a)});
			if (is_read) begin
				check_flag("bk_wr", bk_wr, !rtc);
				check_flag("bk_rtc_wr", bk_rtc_wr, rtc);
			end else begin
				check_word("sd_buff_din", sd_buff_din, rtc ? rtc_word(8'(a)) : bk_q);
			end
			next_cycle();
		end
		sd_buff_wr = 1'b0;
		sd_ack = 1'b0;
	endtask

	initial begin
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr = 1'b0;
		bk_q = '0;
		forever begin
			next_cycle();
			if (!reset && (sd_rd || sd_wr))
				serve_block();
		end
	end

	task automatic wait_idle();
		while (busy)
			next_cycle();
	endtask

	task automatic check_blocks(input logic exp_read, input int last);
		if (lba_log.size() != last + 1) begin
			report_fault($sformatf("saw %0d SD blocks where %0d were due",
				lba_log.size(), last + 1));
		end else begin
			for (int i = 0; i <= last; i++) begin
				check_lba("sd_lba", lba_log[i], 32'(i));
				check_flag("sd_rd", read_log[i], exp_read);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic test_cheat();
		logic [128:0] exp;
		logic [15:0]  w;
		begin_test();
		check_code("gg_code", gg_code, '0);
		repeat (3) begin
			word_q.delete();
			exp = '0;
			for (int i = 0; i < 8; i++) begin
				w = next_rand();
				word_q.push_back(w);
				exp = place_cheat_word(exp, 2 * i, w);
			end
			exp[128] = 1'b1;
			filetype = gb_loader_pkg::FT_CHEAT;
			ioctl_download = 1'b1;
			send_words();
			check_code("gg_code", gg_code, exp);
			ioctl_download = 1'b0;
			next_cycle();
			check_flag("gg_code[128]", gg_code[128], 1'b0);
		end
		end_test("cheat");
	endtask

	task automatic test_cgb_boot();
		begin_test();
		is_gbc = 1'b1;
		check_boot_outputs();
		word_q.delete();
		sum_m = '0;
		repeat (32) add_word(next_rand());
		load_file(gb_loader_pkg::FT_CGB_BOOT);
		custom_cgb_m = 1'b1;
		check_boot_outputs();
		craft_image(int'(gb_loader_pkg::ORIGINAL_CGB_CHECKSUM));
		load_file(gb_loader_pkg::FT_CGB_BOOT);
		check_boot_outputs();
		craft_image(int'(gb_loader_pkg::MISTER_CGB_CHECKSUM));
		load_file(gb_loader_pkg::FT_CGB_BOOT);
		check_boot_outputs();
		end_test("cgb_boot");
	endtask

	task automatic test_dmg_boot();
		begin_test();
		is_gbc = 1'b0;
		next_cycle();
		check_boot_outputs();
		word_q.delete();
		repeat (8) word_q.push_back(next_rand());
		load_file(gb_loader_pkg::FT_DMG_BOOT);
		custom_dmg_m = 1'b1;
		check_boot_outputs();
		// Unrelated file must not bring fast boot back
		load_file(8'h02);
		repeat (4) next_cycle();
		check_boot_outputs();
		end_test("dmg_boot");
	endtask

	task automatic test_cart_load();
		logic [15:0] r;
		begin_test();
		r = next_rand();
		ram_mask_file = {6'd0, r[1:0]};
		rtc_inuse = r[2];
		cart_has_save = 1'b1;
		img_size_nz = 1'b1;
		img_readonly = 1'b0;
		filetype = 8'h01;
		ioctl_download = 1'b1;
		next_cycle();
		img_mounted = 1'b1;
		word_q.delete();
		repeat (16) word_q.push_back(next_rand());
		send_words();
		img_mounted = 1'b0;
		lba_log.delete();
		read_log.delete();
		ioctl_download = 1'b0;
		next_cycle();
		check_flag("sd_rd", sd_rd, 1'b1);
		check_flag("sd_wr", sd_wr, 1'b0);
		check_lba("sd_lba", sd_lba, '0);
		check_flag("bk_loading", bk_loading, 1'b1);
		wait_idle();
		check_flag("bk_loading", bk_loading, 1'b0);
		check_blocks(1'b1, int'(ram_mask_file) + int'(rtc_inuse));
		end_test("cart_load");
	endtask

	task automatic test_rtc_save();
		begin_test();
		rtc_inuse = 1'b1;
		rtc_timestamp = {next_rand(), next_rand()};
		rtc_saved = {next_rand(), next_rand(), next_rand()};
		lba_log.delete();
		read_log.delete();
		bk_save_req = 1'b1;
		next_cycle();
		check_flag("sd_wr", sd_wr, 1'b1);
		check_flag("sd_rd", sd_rd, 1'b0);
		check_lba("sd_lba", sd_lba, '0);
		check_flag("busy", busy, 1'b1);
		bk_save_req = 1'b0;
		wait_idle();
		check_flag("bk_loading", bk_loading, 1'b0);
		check_blocks(1'b0, int'(ram_mask_file) + 1);
		end_test("rtc_save");
	endtask

	task automatic test_autosave();
		begin_test();
		autosave_en = 1'b1;
		osd_status = 1'b0;
		check_flag("sav_pending", sav_pending, 1'b0);
		cram_wr = 1'b1;
		next_cycle();
		cram_wr = 1'b0;
		check_flag("sav_pending", sav_pending, 1'b1);
		repeat (2) next_cycle();
		// Nothing moves while the OSD stays closed
		check_flag("busy", busy, 1'b0);
		check_flag("sav_pending", sav_pending, 1'b1);
		lba_log.delete();
		read_log.delete();
		osd_status = 1'b1;
		next_cycle();
		check_flag("sav_pending", sav_pending, 1'b0);
		check_flag("sd_wr", sd_wr, 1'b1);
		wait_idle();
		osd_status = 1'b0;
		check_blocks(1'b0, int'(ram_mask_file) + 1);
		end_test("autosave");
	endtask

	initial begin
		reset = 1'b1;
		ioctl_download = 1'b0;
		filetype = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		is_gbc = 1'b1;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nz = 1'b0;
		cart_has_save = 1'b0;
		ram_mask_file = '0;
		rtc_inuse = 1'b0;
		rtc_timestamp = '0;
		rtc_saved = '0;
		cram_wr = 1'b0;
		osd_status = 1'b0;
		autosave_en = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		sum_m = '0;
		custom_cgb_m = 1'b0;
		custom_dmg_m = 1'b0;
		strobe_prev = 1'b0;
		repeat (2) @(posedge clk_sys);
		#5;
		reset = 1'b0;
		next_cycle();

		test_cheat();
		test_cgb_boot();
		test_dmg_boot();
		test_cart_load();
		test_rtc_save();
		test_autosave();

		$display("tests %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tb/gb_loader_properties.sv
/*
 * Concurrent checks on the SD request levels and the cheat load strobe.
 * Bound into the loader top level so the sequencer and cheat outputs are
 * both in view.
 */

module gb_loader_properties (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic busy,
	input logic gg_strobe
);

	timeunit 1ns;
	timeprecision 1ps;

	// A block is either read or written, never both
	a_single_request: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high in the same cycle");

	a_request_busy: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> busy)
		else $error("SD request while the sequencer is idle");

	// Strobe is a single-cycle pulse
	a_strobe_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		gg_strobe |=> !gg_strobe)
		else $error("cheat load strobe held for two cycles");

endmodule

bind gb_loader_top gb_loader_properties props_i (
	.clk_sys(clk_sys), .reset(reset), .sd_rd(sd_rd), .sd_wr(sd_wr),
	.busy(busy), .gg_strobe(gg_code[128])
);

// File: hdl/gb_loader_top.sv
/*
 * Top level of the host loader. Connects the download decoder to the boot
 * ROM tracker, the cheat loader and the backup RAM sequencer.
 */

module gb_loader_top (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  logic                                   ioctl_download,
	input  logic [7:0]                             filetype,
	input  logic                                   ioctl_wr,
	input  logic [gb_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [gb_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                   is_gbc,
	input  logic                                   img_mounted,
	input  logic                                   img_readonly,
	input  logic                                   img_size_nz,
	input  logic                                   cart_has_save,
	input  logic [7:0]                             ram_mask_file,
	input  logic                                   rtc_inuse,
	input  logic [gb_loader_pkg::RTC_TS_W-1:0]     rtc_timestamp,
	input  logic [gb_loader_pkg::RTC_SAVED_W-1:0]  rtc_saved,
	input  logic                                   cram_wr,
	input  logic                                   osd_status,
	input  logic                                   autosave_en,
	input  logic                                   bk_load_req,
	input  logic                                   bk_save_req,
	input  logic                                   sd_ack,
	input  logic [7:0]                             sd_buff_addr,
	input  logic                                   sd_buff_wr,
	input  logic [gb_loader_pkg::IOCTL_DATA_W-1:0] bk_q,
	output logic                                   fastboot_available,
	output logic                                   boot_gba_available,
	output logic                                   using_real_cgb_bios,
	output logic [gb_loader_pkg::GG_CODE_W-1:0]    gg_code,
	output logic [gb_loader_pkg::SD_LBA_W-1:0]     sd_lba,
	output logic                                   sd_rd,
	output logic                                   sd_wr,
	output logic [gb_loader_pkg::IOCTL_DATA_W-1:0] sd_buff_din,
	output logic [gb_loader_pkg::BK_ADDR_W-1:0]    bk_addr,
	output logic                                   bk_wr,
	output logic                                   bk_rtc_wr,
	output logic                                   bk_loading,
	output logic                                   sav_pending,
	output logic                                   busy
);

	gb_loader_pkg::dl_kind_t dl_kind;
	logic                    dl_start;
	logic                    dl_end;

	download_decoder decoder_i (
		.clk_sys(clk_sys), .reset(reset), .ioctl_download(ioctl_download),
		.filetype(filetype), .dl_kind(dl_kind), .dl_start(dl_start), .dl_end(dl_end)
	);

	boot_rom_tracker boot_i (
		.clk_sys(clk_sys), .reset(reset), .ioctl_wr(ioctl_wr), .is_gbc(is_gbc),
		.ioctl_dout(ioctl_dout), .dl_kind(dl_kind), .dl_start(dl_start),
		.fastboot_available(fastboot_available), .boot_gba_available(boot_gba_available),
		.using_real_cgb_bios(using_real_cgb_bios)
	);

	// Cheat words sit at byte offsets 0 to 14
	cheat_code_loader cheat_i (
		.clk_sys(clk_sys), .reset(reset), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr[3:0]), .ioctl_dout(ioctl_dout), .dl_kind(dl_kind),
		.gg_code(gg_code)
	);

	backup_ram_sequencer backup_i (
		.clk_sys(clk_sys), .reset(reset), .dl_kind(dl_kind), .dl_start(dl_start),
		.dl_end(dl_end), .img_mounted(img_mounted), .img_readonly(img_readonly),
		.img_size_nz(img_size_nz), .cart_has_save(cart_has_save),
		.ram_mask_file(ram_mask_file), .rtc_inuse(rtc_inuse),
		.rtc_timestamp(rtc_timestamp), .rtc_saved(rtc_saved), .cram_wr(cram_wr),
		.osd_status(osd_status), .autosave_en(autosave_en), .bk_load_req(bk_load_req),
		.bk_save_req(bk_save_req), .sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr),
		.sd_buff_wr(sd_buff_wr), .bk_q(bk_q), .sd_lba(sd_lba), .sd_rd(sd_rd),
		.sd_wr(sd_wr), .sd_buff_din(sd_buff_din), .bk_addr(bk_addr), .bk_wr(bk_wr),
		.bk_rtc_wr(bk_rtc_wr), .bk_loading(bk_loading), .sav_pending(sav_pending),
		.busy(busy)
	);

endmodule

// File: hdl/backup_ram_sequencer.sv
/*
 * Moves battery-backed cart RAM to and from the SD image one 512-byte block
 * at a time. A cart with a running clock gets one extra block holding the
 * RTC state. Also tracks unsaved writes and starts an autosave when the OSD
 * opens.
 */

module backup_ram_sequencer (
	input  logic                                      clk_sys,
	input  logic                                      reset,
	input  gb_loader_pkg::dl_kind_t                   dl_kind,
	input  logic                                      dl_start,
	input  logic                                      dl_end,
	input  logic                                      img_mounted,
	input  logic                                      img_readonly,
	input  logic                                      img_size_nz,
	input  logic                                      cart_has_save,
	input  logic [7:0]                                ram_mask_file,
	input  logic                                      rtc_inuse,
	input  logic [gb_loader_pkg::RTC_TS_W-1:0]        rtc_timestamp,
	input  logic [gb_loader_pkg::RTC_SAVED_W-1:0]     rtc_saved,
	input  logic                                      cram_wr,
	input  logic                                      osd_status,
	input  logic                                      autosave_en,
	input  logic                                      bk_load_req,
	input  logic                                      bk_save_req,
	input  logic                                      sd_ack,
	input  logic [7:0]                                sd_buff_addr,
	input  logic                                      sd_buff_wr,
	input  logic [gb_loader_pkg::IOCTL_DATA_W-1:0]    bk_q,
	output logic [gb_loader_pkg::SD_LBA_W-1:0]        sd_lba,
	output logic                                      sd_rd,
	output logic                                      sd_wr,
	output logic [gb_loader_pkg::IOCTL_DATA_W-1:0]    sd_buff_din,
	output logic [gb_loader_pkg::BK_ADDR_W-1:0]       bk_addr,
	output logic                                      bk_wr,
	output logic                                      bk_rtc_wr,
	output logic                                      bk_loading,
	output logic                                      sav_pending,
	output logic                                      busy
);

	gb_loader_pkg::bk_state_t bk_state;

	logic       old_load;
	logic       old_save;
	logic       old_ack;
	logic       old_mounted;
	logic       was_cart;
	logic       bk_ena;
	logic       sav_supported;
	logic       save_trig;
	logic       load_start;
	logic       save_start;
	logic       rtc_blk;
	logic       last_blk;
	logic [8:0] last_lba;

	assign busy          = (bk_state == gb_loader_pkg::BK_BUSY);
	assign sav_supported = cart_has_save & bk_ena;

	// Manual save, or autosave once the OSD opens with unsaved data
	assign save_trig = bk_save_req | (sav_pending & osd_status & autosave_en);

	// Load wins when both arrive together
	assign load_start = !busy && ((bk_load_req && !old_load)
		|| (dl_end && was_cart && img_size_nz && bk_ena));
	assign save_start = !busy && !load_start && save_trig && !old_save;

	// Nine bits so the RTC block past a full 256-block RAM still counts
	assign last_lba = {1'b0, ram_mask_file} + {8'd0, rtc_inuse};
	assign last_blk = (sd_lba[8:0] >= last_lba);
	assign rtc_blk  = (sd_lba[8:0] > {1'b0, ram_mask_file});

	////////////////////////////////////////////////////////////////////////////
	// Image mount and pending-save tracking

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_mounted <= 1'b0;
			was_cart    <= 1'b0;
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			old_mounted <= img_mounted;
			was_cart    <= (dl_kind == gb_loader_pkg::DL_CART);

			// Host mounts the save file near the end of the ROM download
			if (dl_start && dl_kind == gb_loader_pkg::DL_CART)
				bk_ena <= 1'b0;
			else if (dl_kind == gb_loader_pkg::DL_CART && img_mounted && !old_mounted
				&& !img_readonly)
				bk_ena <= 1'b1;

			if (load_start || save_start)
				sav_pending <= 1'b0;
			else if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Block transfer FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_state   <= gb_loader_pkg::BK_IDLE;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_load <= bk_load_req;
			old_save <= save_trig;
			old_ack  <= sd_ack;

			// Host has taken the request
			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (bk_state)
				gb_loader_pkg::BK_IDLE: begin
					if (load_start || save_start) begin
						bk_state   <= gb_loader_pkg::BK_BUSY;
						bk_loading <= load_start;
						sd_lba     <= '0;
						sd_rd      <= load_start;
						sd_wr      <= save_start;
					end
				end
				gb_loader_pkg::BK_BUSY: begin
					// Block finished, move on or stop
					if (old_ack && !sd_ack) begin
						if (last_blk) begin
							bk_state   <= gb_loader_pkg::BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
						end
					end
				end
				default: bk_state <= gb_loader_pkg::BK_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// RAM port and RTC block data

	assign bk_addr   = {1'b0, sd_lba[7:0], sd_buff_addr};
	assign bk_wr     = sd_buff_wr & sd_ack & ~rtc_blk;
	assign bk_rtc_wr = sd_buff_wr & sd_ack & rtc_blk;

	always_comb begin
		if (!rtc_blk) begin
			sd_buff_din = bk_q;
		end else begin
			case (sd_buff_addr)
				8'd0:    sd_buff_din = rtc_timestamp[15:0];
				8'd1:    sd_buff_din = rtc_timestamp[31:16];
				8'd2:    sd_buff_din = rtc_saved[15:0];
				8'd3:    sd_buff_din = rtc_saved[31:16];
				8'd4:    sd_buff_din = rtc_saved[47:32];
				default: sd_buff_din = 16'hFFFF;
			endcase
		end
	end

endmodule

// File: hdl/cheat_code_loader.sv
/*
 * Builds one cheat code from the eight 16-bit words of a cheat download.
 * Layout is {strobe, flags, address, compare, replace}. Bit 128 pulses for
 * one cycle once the final word has landed.
 */

module cheat_code_loader (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  logic                                   ioctl_wr,
	input  logic [3:0]                             ioctl_addr,
	input  logic [gb_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  gb_loader_pkg::dl_kind_t                dl_kind,
	output logic [gb_loader_pkg::GG_CODE_W-1:0]    gg_code
);

	logic code_wr;

	assign code_wr = ioctl_wr && (dl_kind == gb_loader_pkg::DL_CHEAT);

	// Load strobe
	always_ff @(posedge clk_sys) begin
		if (reset)
			gg_code[128] <= 1'b0;
		else
			gg_code[128] <= code_wr && (ioctl_addr == gb_loader_pkg::CHEAT_LAST_OFFSET);
	end

	// Code fields, lower offset fills the low half
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg_code[127:0] <= '0;
		end else if (code_wr) begin
			case (ioctl_addr)
				4'd0:  gg_code[111:96]  <= ioctl_dout;
				4'd2:  gg_code[127:112] <= ioctl_dout;
				4'd4:  gg_code[79:64]   <= ioctl_dout;
				4'd6:  gg_code[95:80]   <= ioctl_dout;
				4'd8:  gg_code[47:32]   <= ioctl_dout;
				4'd10: gg_code[63:48]   <= ioctl_dout;
				4'd12: gg_code[15:0]    <= ioctl_dout;
				gb_loader_pkg::CHEAT_LAST_OFFSET: gg_code[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

endmodule

// File: hdl/boot_rom_tracker.sv
/*
 * Remembers which custom boot ROMs the host has loaded and keeps a byte sum
 * of the colour boot ROM. The sum tells a known image apart, which decides
 * whether fast boot and GBA mode can be offered in the menu.
 */

module boot_rom_tracker (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    ioctl_wr,
	input  logic                                    is_gbc,
	input  logic [gb_loader_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
	input  gb_loader_pkg::dl_kind_t                 dl_kind,
	input  logic                                    dl_start,
	output logic                                    fastboot_available,
	output logic                                    boot_gba_available,
	output logic                                    using_real_cgb_bios
);

	logic                                 custom_cgb;
	logic                                 custom_dmg;
	logic [gb_loader_pkg::CHECKSUM_W-1:0] checksum;
	logic [gb_loader_pkg::CHECKSUM_W-1:0] word_sum;
	logic                                 cgb_dl;

	assign cgb_dl = (dl_kind == gb_loader_pkg::DL_CGB_BOOT);

	// Both bytes of the current download word
	assign word_sum = gb_loader_pkg::CHECKSUM_W'(ioctl_dout[15:8])
		+ gb_loader_pkg::CHECKSUM_W'(ioctl_dout[7:0]);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_cgb <= 1'b0;
			custom_dmg <= 1'b0;
			checksum   <= '0;
		end else begin
			if (cgb_dl)
				custom_cgb <= 1'b1;
			if (dl_kind == gb_loader_pkg::DL_DMG_BOOT)
				custom_dmg <= 1'b1;

			// New image restarts the sum, a write in the first cycle still counts
			if (cgb_dl && dl_start)
				checksum <= ioctl_wr ? word_sum : '0;
			else if (cgb_dl && ioctl_wr)
				checksum <= checksum + word_sum;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Feature availability

	// Fast boot needs a MiSTer-built colour ROM or the stock mono ROM
	assign fastboot_available = !((is_gbc && custom_cgb
		&& checksum != gb_loader_pkg::MISTER_CGB_CHECKSUM)
		|| (!is_gbc && custom_dmg));

	assign using_real_cgb_bios = (checksum == gb_loader_pkg::ORIGINAL_CGB_CHECKSUM);

	assign boot_gba_available = !custom_cgb || using_real_cgb_bios
		|| checksum == gb_loader_pkg::MISTER_CGB_CHECKSUM;

endmodule

// File: hdl/download_decoder.sv
/*
 * Classifies the host download by file type and marks its first cycle and
 * the cycle after it ends. The kind is combinational and reads DL_NONE
 * whenever no download is running.
 */

module download_decoder (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  logic [7:0]              filetype,
	output gb_loader_pkg::dl_kind_t dl_kind,
	output logic                    dl_start,
	output logic                    dl_end
);

	logic dl_prev;

	always_comb begin
		dl_kind = gb_loader_pkg::DL_NONE;
		if (ioctl_download) begin
			if (filetype == gb_loader_pkg::FT_CHEAT)
				dl_kind = gb_loader_pkg::DL_CHEAT;
			// Any type ending in 6'h01 is a ROM image from the cart menu
			else if (filetype[5:0] == 6'h01 || filetype == gb_loader_pkg::FT_CART_ALT)
				dl_kind = gb_loader_pkg::DL_CART;
			else if (filetype == gb_loader_pkg::FT_CGB_BOOT)
				dl_kind = gb_loader_pkg::DL_CGB_BOOT;
			else if (filetype == gb_loader_pkg::FT_DMG_BOOT)
				dl_kind = gb_loader_pkg::DL_DMG_BOOT;
			else
				dl_kind = gb_loader_pkg::DL_OTHER;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			dl_prev <= 1'b0;
		else
			dl_prev <= ioctl_download;
	end

	assign dl_start = ioctl_download & ~dl_prev;
	assign dl_end   = ~ioctl_download & dl_prev;

endmodule

// File: hdl/gb_loader_pkg.sv
/*
 * Shared types and constants for the host loader of the handheld console core.
 * Every RTL file refers to these by scoped name. Holds the download kinds, the
 * backup sequencer states, file-type codes, bus widths and boot ROM checksums.
 */

package gb_loader_pkg;

	// Kind of file the host is currently sending
	typedef enum logic [2:0] {
		DL_NONE,
		DL_CART,
		DL_CGB_BOOT,
		DL_DMG_BOOT,
		DL_CHEAT,
		DL_OTHER
	} dl_kind_t;

	// Backup RAM block transfer state
	typedef enum logic {
		BK_IDLE,
		BK_BUSY
	} bk_state_t;

	// File-type codes from the host menu
	localparam logic [7:0] FT_CGB_BOOT = 8'h04;
	localparam logic [7:0] FT_DMG_BOOT = 8'h05;
	localparam logic [7:0] FT_CART_ALT = 8'h80;
	localparam logic [7:0] FT_CHEAT    = 8'hFF;

	// Download bus
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;

	// Colour boot ROM byte sum and the two known images
	localparam int CHECKSUM_W = 18;
	localparam logic [CHECKSUM_W-1:0] MISTER_CGB_CHECKSUM   = 18'h2E351;
	localparam logic [CHECKSUM_W-1:0] ORIGINAL_CGB_CHECKSUM = 18'h2F3EA;

	// Cheat code, bit 128 is the load strobe
	localparam int GG_CODE_W = 129;
	localparam logic [3:0] CHEAT_LAST_OFFSET = 4'd14;

	// Backup RAM and RTC
	localparam int SD_LBA_W    = 32;
	localparam int BK_ADDR_W   = 17;
	localparam int RTC_TS_W    = 32;
	localparam int RTC_SAVED_W = 48;

endpackage
